/* tb/ship_link_patterns.hex */
// player_number, dest select (0 own, 1 other player, 2 master), extra payload words,
// payload words 0 to 10, ship_cmd (64 bits)
0_0_00_3210_7654_ba98_fedc_0123_4567_89ab_0003_0040_0025_beef_fac6_88a5_1234_5678
0_1_00_1111_2222_3333_4444_5555_6666_7777_0001_00aa_00bb_cccc_0000_0000_0000_0000
0_2_02_aaaa_bbbb_cccc_dddd_eeee_ffff_0000_0005_0011_0022_0033_ffff_ffff_ffff_ffff
0_0_03_0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_0002_0101_0202_5a5a_2493_6db6_aa55_c3c3
1_0_00_1357_9bdf_2468_ace0_fedc_ba98_7654_0004_0120_0080_1e1e_5555_aaaa_0f0f_f0f0
1_1_00_dead_beef_cafe_f00d_0bad_c0de_feed_0003_0333_0444_0555_1234_1234_1234_1234
1_0_3a_0001_0010_0100_1000_0002_0020_0200_0005_07ff_0001_9999_b6db_4924_8421_7e7e
0_0_00_8888_9999_aaaa_bbbb_cccc_dddd_eeee_0001_0003_0004_4242_0000_ffff_0000_ffff
1_2_05_4321_8765_cba9_0fed_3210_7654_ba98_0000_0010_0020_0030_6789_abcd_ef01_2345
0_1_00_5a5a_a5a5_5a5a_a5a5_5a5a_a5a5_5a5a_0002_0001_0002_0003_1111_2222_3333_4444
0_0_10_0123_1234_2345_3456_4567_5678_6789_0000_00ff_0100_abcd_9248_9249_0042_0077
1_0_00_ffff_0000_ffff_0000_ffff_0000_ffff_0005_fff0_000f_0f0f_edb7_1c71_c71c_8001

/* all.f */
logic/ship_link_pkg.sv
logic/packet_buffer.sv
logic/word_countdown.sv
logic/frame_receiver.sv
logic/frame_transmitter.sv
logic/game_sequencer.sv
logic/ship_link_top.sv
tb/ship_link_tb.sv

/* Bender.yml */
package:
  name: ship_link

sources:
  - logic/ship_link_pkg.sv
  - logic/packet_buffer.sv
  - logic/word_countdown.sv
  - logic/frame_receiver.sv
  - logic/frame_transmitter.sv
  - logic/game_sequencer.sv
  - logic/ship_link_top.sv
  - target: test
    files:
      - tb/ship_link_tb.sv

/* tb/ship_link_tb.sv */
//**************************************************
// Self-checking testbench for the ship packet link.
// Run from the project root so the pattern file is found.
// Receive FIFO is a show-ahead queue, the transmit sink
// reports full on about one third of the cycles.
//**************************************************
`timescale 1ns/1ns

module ship_link_tb;
	import ship_link_pkg::*;

	localparam int N_PATTERNS = 12;
	localparam int RESP_WORDS = 10; // header plus command words
	localparam int SETTLE_CYCLES = 40; // longer than one sequencer pass

	logic clk = 1'b0;
	logic rst_n;
	logic player_number;
	ship_cmd_t ship_cmd;
	game_state_t game_state;
	logic rx_fifo_empty;
	word_t rx_fifo_rd_data;
	logic rx_fifo_rd_req;
	logic tx_fifo_full;
	logic tx_fifo_wr_req;
	word_t tx_fifo_wr_data;

	logic [255:0] patterns [N_PATTERNS];
	word_t rx_q [$];
	word_t tx_q [$];
	integer seed;
	int mismatches;
	int failures;
	game_state_t exp_state;

	ship_link_top #(.BUF_ADDR_W(6)) i_ship_link_top (
		.clk(clk), .rst_n(rst_n), .player_number(player_number), .ship_cmd(ship_cmd),
		.game_state(game_state), .rx_fifo_empty(rx_fifo_empty),
		.rx_fifo_rd_data(rx_fifo_rd_data), .rx_fifo_rd_req(rx_fifo_rd_req),
		.tx_fifo_full(tx_fifo_full), .tx_fifo_wr_req(tx_fifo_wr_req),
		.tx_fifo_wr_data(tx_fifo_wr_data)
	);

	always #10 clk = ~clk;

	// FIFO models
	always @(posedge clk)
	begin
		logic pop;
		pop = rx_fifo_rd_req && !rx_fifo_empty;
		if (rx_fifo_rd_req && rx_fifo_empty)
		begin
			$display("Error at %0t: receive FIFO popped while empty", $time);
			failures++;
		end
		if (tx_fifo_wr_req && tx_fifo_full)
		begin
			$display("Error at %0t: transmit FIFO written while full", $time);
			failures++;
		end
		else if (tx_fifo_wr_req)
			tx_q.push_back(tx_fifo_wr_data);
		#2;
		if (pop && rx_q.size() > 0)
			void'(rx_q.pop_front());
		rx_fifo_empty = (rx_q.size() == 0);
		rx_fifo_rd_data = rx_fifo_empty ? 16'h0000 : rx_q[0]; // show-ahead head word
		tx_fifo_full = rst_n && (($unsigned($random(seed)) % 3) == 0);
	end

	function automatic word_t byte_swap(input word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic report_word(input string name, input word_t exp, input word_t act);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		mismatches++;
	endtask

	task automatic push_frame(input mac_t dest, input word_t pay [RX_PAYLOAD_WORDS],
			input int extra);
		rx_q.push_back(word_t'(2 * (RX_PAYLOAD_WORDS + extra))); // byte length
		for (int i = 0; i < 3; i++)
			rx_q.push_back(byte_swap(dest[47 - 16 * i -: 16]));
		for (int i = 0; i < 3; i++)
			rx_q.push_back(word_t'($random(seed))); // source address, ignored
		rx_q.push_back(16'h0800);
		for (int i = 0; i < RX_PAYLOAD_WORDS; i++)
			rx_q.push_back(pay[i]);
		for (int i = 0; i < extra; i++)
			rx_q.push_back(word_t'($random(seed)));
	endtask

	task automatic check_response(input ship_cmd_t cmd);
		word_t exp_resp [RESP_WORDS];
		exp_resp[0] = word_t'(2 * TX_PAYLOAD_WORDS);
		exp_resp[1] = MASTER_MAC[47:32];
		exp_resp[2] = MASTER_MAC[31:16];
		exp_resp[3] = MASTER_MAC[15:0];
		exp_resp[4] = SHIP_ETHER_TYPE;
		exp_resp[5] = {cmd.hookup[0], cmd.hookup[1], cmd.hookup[2], cmd.hookup[3],
			cmd.engines_on, 3'b000};
		exp_resp[6] = {cmd.hookup[4], cmd.hookup[5], cmd.hookup[6], cmd.hookup[7],
			cmd.engines_dir, 2'b00};
		exp_resp[7] = {cmd.sensor_rate, cmd.sensor_move, 6'b000000};
		exp_resp[8] = {cmd.cannon_fire, cmd.cannon_power, 5'b00000};
		exp_resp[9] = cmd.tx_checksum;
		for (int i = 0; i < RESP_WORDS; i++)
		begin
			if (tx_q[i] !== exp_resp[i])
				report_word($sformatf("tx_fifo_wr_data word %0d", i), exp_resp[i], tx_q[i]);
		end
	endtask

	task automatic run_pattern(input logic [255:0] pat);
		logic pn;
		logic [3:0] sel;
		int extra;
		word_t pay [RX_PAYLOAD_WORDS];
		ship_cmd_t cmd;
		mac_t dest;
		pn = pat[252];
		sel = pat[251:248];
		extra = pat[247:240];
		for (int i = 0; i < RX_PAYLOAD_WORDS; i++)
			pay[i] = pat[239 - 16 * i -: 16];
		cmd = pat[63:0];
		if (sel == 4'd0)
			dest = pn ? PLAYER2_MAC : PLAYER1_MAC;
		else if (sel == 4'd1)
			dest = pn ? PLAYER1_MAC : PLAYER2_MAC; // the other player
		else
			dest = MASTER_MAC;
		@(posedge clk);
		#2;
		player_number = pn;
		ship_cmd = cmd;
		@(negedge clk);
		push_frame(dest, pay, extra);
		if (sel == 4'd0)
		begin
			for (int w = 0; w < 7; w++)
				for (int k = 0; k < 4; k++)
					exp_state.power[4 * w + k] = pay[w][4 * k +: 4]; // lowest nibble first
			exp_state.sensor = sensor_event_e'(pay[7][3:0]);
			exp_state.x_coord = pay[8];
			exp_state.y_coord = pay[9];
			exp_state.rx_checksum = pay[10];
			while (tx_q.size() < RESP_WORDS)
				@(negedge clk);
			if (game_state !== exp_state)
			begin
				$display("Mismatch at %0t: game_state expected %h, got %h",
					$time, exp_state, game_state);
				mismatches++;
			end
			check_response(cmd);
			tx_q.delete();
		end
		else
		begin
			while (rx_q.size() != 0)
				@(negedge clk);
			repeat (SETTLE_CYCLES) @(negedge clk); // give a wrong response time to show
			if (tx_q.size() != 0)
			begin
				$display("Error at %0t: response sent to a frame for another station", $time);
				failures++;
				tx_q.delete();
			end
			if (game_state !== exp_state)
			begin
				$display("Mismatch at %0t: game_state expected %h, got %h",
					$time, exp_state, game_state);
				mismatches++;
			end
		end
		if (rx_q.size() != 0)
		begin
			$display("Error at %0t: frame not fully consumed by the receiver", $time);
			failures++;
		end
	endtask

	task finish_run;
		$display("Done: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches + failures == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	initial
	begin
		seed = 32'h3686_9322;
		rst_n = 1'b0;
		player_number = 1'b0;
		ship_cmd = '0;
		rx_fifo_empty = 1'b1;
		rx_fifo_rd_data = '0;
		tx_fifo_full = 1'b0;
		mismatches = 0;
		failures = 0;
		exp_state = '0;
		$readmemh("tb/ship_link_patterns.hex", patterns);
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		if (game_state !== '0)
		begin
			$display("Mismatch at %0t: game_state expected %h, got %h",
				$time, exp_state, game_state);
			mismatches++;
		end
		if (tx_fifo_wr_req !== 1'b0)
		begin
			$display("Mismatch at %0t: tx_fifo_wr_req expected 0, got %b", $time, tx_fifo_wr_req);
			mismatches++;
		end
		if (rx_fifo_rd_req !== 1'b0)
		begin
			$display("Mismatch at %0t: rx_fifo_rd_req expected 0, got %b", $time, rx_fifo_rd_req);
			mismatches++;
		end
		for (int p = 0; p < N_PATTERNS; p++)
			run_pattern(patterns[p]);
		repeat (SETTLE_CYCLES) @(negedge clk);
		if (tx_q.size() != 0)
		begin
			$display("Error at %0t: transmit words left after the last frame", $time);
			failures++;
		end
		finish_run();
	end

	// watchdog
	initial
	begin
		repeat (N_PATTERNS * 600) @(posedge clk);
		$display("Error at %0t: timeout, the DUT stopped making progress", $time);
		failures++;
		finish_run();
	end

endmodule

/* logic/ship_link_top.sv */
//**************************************************
// Packet layer of the ship game, from the receive FIFO
// to the transmit FIFO. One response frame follows each
// frame addressed to this player.
// BUF_ADDR_W must not exceed BUF_ADDR_FIELD_W.
//**************************************************
`timescale 1ns/1ns

module ship_link_top #(
	parameter int BUF_ADDR_W = 6
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        player_number,
	input  ship_link_pkg::ship_cmd_t    ship_cmd,
	output ship_link_pkg::game_state_t  game_state,
	input  logic                        rx_fifo_empty,
	input  ship_link_pkg::word_t        rx_fifo_rd_data,
	output logic                        rx_fifo_rd_req,
	input  logic                        tx_fifo_full,
	output logic                        tx_fifo_wr_req,
	output ship_link_pkg::word_t        tx_fifo_wr_data
);
	import ship_link_pkg::*;

	buf_wr_t rx_wr;
	buf_wr_t tx_wr;
	logic [BUF_ADDR_W-1:0] rx_rd_addr;
	logic [BUF_ADDR_W-1:0] tx_rd_addr;
	word_t rx_rd_data;
	word_t tx_rd_data;
	logic frame_found;
	logic rx_lock;
	logic send_start;
	logic tx_idle;

	packet_buffer #(.ADDR_W(BUF_ADDR_W)) i_rx_buffer (
		.clk(clk), .wr(rx_wr), .rd_addr(rx_rd_addr), .rd_data(rx_rd_data)
	);

	packet_buffer #(.ADDR_W(BUF_ADDR_W)) i_tx_buffer (
		.clk(clk), .wr(tx_wr), .rd_addr(tx_rd_addr), .rd_data(tx_rd_data)
	);

	frame_receiver #(.ADDR_W(BUF_ADDR_W)) i_frame_receiver (
		.clk(clk), .rst_n(rst_n), .player_number(player_number), .rx_lock(rx_lock),
		.rx_fifo_empty(rx_fifo_empty), .rx_fifo_rd_data(rx_fifo_rd_data),
		.rx_fifo_rd_req(rx_fifo_rd_req), .rx_wr(rx_wr), .frame_found(frame_found)
	);

	game_sequencer #(.ADDR_W(BUF_ADDR_W)) i_game_sequencer (
		.clk(clk), .rst_n(rst_n), .frame_found(frame_found), .rx_rd_addr(rx_rd_addr),
		.rx_rd_data(rx_rd_data), .ship_cmd(ship_cmd), .tx_idle(tx_idle),
		.rx_lock(rx_lock), .tx_wr(tx_wr), .send_start(send_start), .game_state(game_state)
	);

	frame_transmitter #(.ADDR_W(BUF_ADDR_W)) i_frame_transmitter (
		.clk(clk), .rst_n(rst_n), .send_start(send_start), .tx_idle(tx_idle),
		.buf_rd_addr(tx_rd_addr), .buf_rd_data(tx_rd_data), .tx_fifo_full(tx_fifo_full),
		.tx_fifo_wr_req(tx_fifo_wr_req), .tx_fifo_wr_data(tx_fifo_wr_data)
	);

endmodule

/* logic/game_sequencer.sv */
//**************************************************
// Unpacks a stored frame into the game state, then
// packs the ship command into the transmit buffer.
// rx_lock is held from frame_found until send_start,
// so no stored frame is overwritten or missed.
//**************************************************
`timescale 1ns/1ns

module game_sequencer #(
	parameter int ADDR_W = 6
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        frame_found,
	output logic [ADDR_W-1:0]           rx_rd_addr,
	input  ship_link_pkg::word_t        rx_rd_data,
	input  ship_link_pkg::ship_cmd_t    ship_cmd,
	input  logic                        tx_idle,
	output logic                        rx_lock,
	output ship_link_pkg::buf_wr_t      tx_wr,
	output logic                        send_start,
	output ship_link_pkg::game_state_t  game_state
);
	import ship_link_pkg::*;

	seq_state_e state;
	logic [3:0] rd_idx;
	logic [2:0] wr_idx;
	ship_cmd_t cmd_q;
	word_t cmd_word;
	logic wr_we;
	logic [ADDR_W-1:0] wr_addr;
	word_t wr_data;

	assign rx_rd_addr = ADDR_W'(rd_idx);
	assign tx_wr = '{addr: BUF_ADDR_FIELD_W'(wr_addr), data: wr_data, we: wr_we};

	always_comb
	begin
		case (wr_idx)
			3'd0:    cmd_word = {cmd_q.hookup[0:3], cmd_q.engines_on, 3'b000};
			3'd1:    cmd_word = {cmd_q.hookup[4:7], cmd_q.engines_dir, 2'b00};
			3'd2:    cmd_word = {cmd_q.sensor_rate, cmd_q.sensor_move, 6'b000000};
			3'd3:    cmd_word = {cmd_q.cannon_fire, cmd_q.cannon_power, 5'b00000};
			default: cmd_word = cmd_q.tx_checksum;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= seq_idle;
			rd_idx <= '0;
			wr_idx <= '0;
			rx_lock <= 1'b0;
			send_start <= 1'b0;
			wr_we <= 1'b0;
			game_state <= '0;
		end
		else
		begin
			send_start <= 1'b0;
			case (state)
				seq_idle:
				begin
					if (frame_found)
					begin
						rx_lock <= 1'b1;
						rd_idx <= '0;
						state <= seq_read_addr;
					end
				end
				seq_read_addr: state <= seq_read_data; // buffer read latency
				seq_read_data:
				begin
					if (rd_idx < 4'd7)
					begin
						for (int k = 0; k < 4; k++)
							game_state.power[4 * rd_idx + k] <= rx_rd_data[4 * k +: 4];
					end
					else if (rd_idx == 4'd7)
						game_state.sensor <= sensor_event_e'(rx_rd_data[3:0]);
					else if (rd_idx == 4'd8)
						game_state.x_coord <= rx_rd_data;
					else if (rd_idx == 4'd9)
						game_state.y_coord <= rx_rd_data;
					else
						game_state.rx_checksum <= rx_rd_data;

					if (rd_idx == 4'(RX_PAYLOAD_WORDS - 1))
						state <= seq_wait_tx;
					else
					begin
						rd_idx <= rd_idx + 1'b1;
						state <= seq_read_addr;
					end
				end
				seq_wait_tx:
				begin
					if (tx_idle) // previous response fully read out
					begin
						wr_idx <= '0;
						state <= seq_write;
					end
				end
				seq_write:
				begin
					wr_we <= 1'b1;
					wr_idx <= wr_idx + 1'b1;
					if (wr_idx == 3'(TX_PAYLOAD_WORDS - 1))
						state <= seq_send;
				end
				seq_send:
				begin
					wr_we <= 1'b0;
					send_start <= 1'b1;
					rx_lock <= 1'b0;
					state <= seq_idle;
				end
				default: state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == seq_wait_tx) && tx_idle)
			cmd_q <= ship_cmd; // one snapshot per response
		wr_addr <= ADDR_W'(wr_idx);
		wr_data <= cmd_word;
	end

	// transmitter must still be idle when it is started
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		send_start |-> tx_idle);

endmodule

/* logic/frame_transmitter.sv */
//**************************************************
// Streams one response frame into the transmit FIFO.
// Header is built here, the payload comes from the
// transmit buffer at addr 0 with one read cycle per word.
// A full FIFO holds the current word and state.
//**************************************************
`timescale 1ns/1ns

module frame_transmitter #(
	parameter int ADDR_W = 6
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  send_start,
	output logic                  tx_idle,
	output logic [ADDR_W-1:0]     buf_rd_addr,
	input  ship_link_pkg::word_t  buf_rd_data,
	input  logic                  tx_fifo_full,
	output logic                  tx_fifo_wr_req,
	output ship_link_pkg::word_t  tx_fifo_wr_data
);
	import ship_link_pkg::*;

	localparam int HDR_WORDS = 5; // length, three address words, ethertype

	tx_state_e state;
	logic [2:0] idx; // header word or payload address
	logic cnt_load;
	logic [2:0] cnt_value;
	logic cnt_done;
	word_t hdr_word;

	assign tx_idle = (state == tx_wait_start);
	assign buf_rd_addr = ADDR_W'(idx);
	assign cnt_load = (tx_idle && send_start) || ((state == tx_header) && cnt_done);
	assign cnt_value = tx_idle ? 3'(HDR_WORDS) : 3'(TX_PAYLOAD_WORDS);
	assign tx_fifo_wr_req = !tx_fifo_full &&
		(((state == tx_header) && !cnt_done) || (state == tx_payload));
	assign tx_fifo_wr_data = (state == tx_payload) ? buf_rd_data : hdr_word;

	always_comb
	begin
		case (idx)
			3'd0:    hdr_word = word_t'(2 * TX_PAYLOAD_WORDS); // payload bytes
			3'd1:    hdr_word = MASTER_MAC[47:32];
			3'd2:    hdr_word = MASTER_MAC[31:16];
			3'd3:    hdr_word = MASTER_MAC[15:0];
			default: hdr_word = SHIP_ETHER_TYPE;
		endcase
	end

	word_countdown #(
		.CNT_W(3)
	) i_word_cnt (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (cnt_load),
		.load_value(cnt_value),
		.step      (tx_fifo_wr_req),
		.done      (cnt_done)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= tx_wait_start;
			idx <= '0;
		end
		else
		begin
			case (state)
				tx_wait_start:
				begin
					if (send_start)
					begin
						idx <= '0;
						state <= tx_header;
					end
				end
				tx_header:
				begin
					if (cnt_done) // header out, payload count loaded
					begin
						idx <= '0;
						state <= tx_fetch;
					end
					else if (tx_fifo_wr_req)
						idx <= idx + 1'b1;
				end
				tx_fetch: state <= cnt_done ? tx_wait_start : tx_payload; // buffer read
				tx_payload:
				begin
					if (tx_fifo_wr_req)
					begin
						idx <= idx + 1'b1;
						state <= tx_fetch;
					end
				end
				default: state <= tx_wait_start;
			endcase
		end
	end

	// a pending word waits unchanged while the FIFO is full
	a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		tx_fifo_full && ((state == tx_payload) || ((state == tx_header) && !cnt_done))
		|=> $stable(tx_fifo_wr_data) && $stable(idx));

endmodule

/* logic/frame_receiver.sv */
//**************************************************
// Parses frames from a show-ahead receive FIFO.
// Stalls on an empty FIFO anywhere in a frame. Only
// frames for the local player are stored, from addr 0;
// words past the buffer depth are popped and dropped.
//**************************************************
`timescale 1ns/1ns

module frame_receiver #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    player_number,
	input  logic                    rx_lock,
	input  logic                    rx_fifo_empty,
	input  ship_link_pkg::word_t    rx_fifo_rd_data,
	output logic                    rx_fifo_rd_req,
	output ship_link_pkg::buf_wr_t  rx_wr,
	output logic                    frame_found
);
	import ship_link_pkg::*;

	localparam int DEST_WORDS = 3;
	localparam int HDR_WORDS = 7; // destination, source and ethertype

	rx_state_e state;
	logic [2:0] hdr_idx;
	mac_t dest_mac;
	mac_t local_mac;
	word_t swapped;
	logic to_me;
	logic [ADDR_W:0] wr_ptr; // top bit marks a full buffer
	logic len_load;
	logic pay_pop;
	logic pay_done;
	logic wr_we;
	logic [ADDR_W-1:0] wr_addr;
	word_t wr_data;

	assign local_mac = player_number ? PLAYER2_MAC : PLAYER1_MAC;
	assign swapped = {rx_fifo_rd_data[7:0], rx_fifo_rd_data[15:8]};
	assign len_load = (state == rx_idle) && rx_fifo_rd_req;
	assign pay_pop = (state == rx_payload) && rx_fifo_rd_req;
	assign rx_wr = '{addr: BUF_ADDR_FIELD_W'(wr_addr), data: wr_data, we: wr_we};

	// length is in bytes, the counter runs in words
	word_countdown #(
		.CNT_W(FRAME_LEN_W - 1)
	) i_payload_cnt (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (len_load),
		.load_value(rx_fifo_rd_data[FRAME_LEN_W-1:1]),
		.step      (pay_pop),
		.done      (pay_done)
	);

	always_comb
	begin
		case (state)
			rx_idle:    rx_fifo_rd_req = !rx_fifo_empty && !rx_lock && !frame_found;
			rx_header:  rx_fifo_rd_req = !rx_fifo_empty;
			rx_payload: rx_fifo_rd_req = !rx_fifo_empty && !pay_done;
			default:    rx_fifo_rd_req = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= rx_idle;
			hdr_idx <= '0;
			to_me <= 1'b0;
			wr_ptr <= '0;
			wr_we <= 1'b0;
			frame_found <= 1'b0;
		end
		else
		begin
			frame_found <= 1'b0;
			wr_we <= 1'b0;
			case (state)
				rx_idle:
				begin
					if (rx_fifo_rd_req) // length word popped
					begin
						hdr_idx <= '0;
						state <= rx_header;
					end
				end
				rx_header:
				begin
					if (rx_fifo_rd_req)
					begin
						hdr_idx <= hdr_idx + 1'b1;
						if (hdr_idx == 3'(HDR_WORDS - 1))
						begin
							to_me <= (dest_mac == local_mac);
							wr_ptr <= '0;
							state <= rx_payload;
						end
					end
				end
				rx_payload:
				begin
					if (pay_done)
					begin
						frame_found <= to_me; // last write lands this cycle
						state <= rx_idle;
					end
					else if (rx_fifo_rd_req)
					begin
						wr_we <= to_me && !wr_ptr[ADDR_W];
						if (!wr_ptr[ADDR_W])
							wr_ptr <= wr_ptr + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == rx_header) && rx_fifo_rd_req && (hdr_idx < 3'(DEST_WORDS)))
			dest_mac <= {dest_mac[31:0], swapped}; // most significant word first
		wr_addr <= wr_ptr[ADDR_W-1:0];
		wr_data <= rx_fifo_rd_data;
	end

	a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rx_fifo_rd_req |-> !rx_fifo_empty);

endmodule

/* logic/word_countdown.sv */
//**************************************************
// Counts down the words still due in a frame section.
// done rises the cycle after a zero load or after the
// step that reaches zero; steps while done are ignored.
//**************************************************
`timescale 1ns/1ns

module word_countdown #(
	parameter int CNT_W = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic [CNT_W-1:0] load_value,
	input  logic             step,
	output logic             done
);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= '0;
			done <= 1'b1; // nothing due after reset
		end
		else if (load)
		begin
			count <= load_value;
			done <= (load_value == '0);
		end
		else if (step && !done)
		begin
			count <= count - 1'b1;
			done <= (count == CNT_W'(1)); // last word of the section
		end
	end

endmodule

/* logic/packet_buffer.sv */
//**************************************************
// Word buffer with one write port and one read port.
// Read data appears one cycle after the address.
// No reset, contents are undefined until written.
//**************************************************
`timescale 1ns/1ns

module packet_buffer #(
	parameter int ADDR_W = 6
) (
	input  logic                    clk,
	input  ship_link_pkg::buf_wr_t  wr,
	input  logic [ADDR_W-1:0]       rd_addr,
	output ship_link_pkg::word_t    rd_data
);
	import ship_link_pkg::*;

	word_t mem [2**ADDR_W];

	always_ff @(posedge clk)
	begin
		if (wr.we)
			mem[wr.addr[ADDR_W-1:0]] <= wr.data;
		rd_data <= mem[rd_addr]; // registered read
	end

	// the writer must keep its address inside this buffer
	a_wr_addr_known: assert property (@(posedge clk)
		wr.we |-> !$isunknown(wr.addr) && ((wr.addr >> ADDR_W) == '0));

endmodule

/* logic/ship_link_pkg.sv */
//**************************************************
// Shared types and constants of the ship packet link.
// Buffer write ports carry a fixed-width address field
// and modules use only the low ADDR_W bits of it, so
// BUF_ADDR_W at the top must not exceed BUF_ADDR_FIELD_W.
//**************************************************
package ship_link_pkg;

	typedef logic [15:0] word_t;
	typedef logic [47:0] mac_t;

	localparam mac_t MASTER_MAC = 48'h0000_0000_0000;
	localparam mac_t PLAYER1_MAC = 48'h0000_0000_0001; // player_number 0
	localparam mac_t PLAYER2_MAC = 48'h0000_0000_0002; // player_number 1
	localparam word_t SHIP_ETHER_TYPE = 16'h0A0A;

	localparam int RX_PAYLOAD_WORDS = 11; // game state words read back
	localparam int TX_PAYLOAD_WORDS = 5; // command words sent
	localparam int FRAME_LEN_W = 11; // used bits of the byte length
	localparam int BUF_ADDR_FIELD_W = 8; // widest supported buffer address

	typedef enum logic [3:0] {
		sensor_none = 4'd0,
		sensor_ship = 4'd1,
		sensor_wall_n = 4'd2,
		sensor_wall_s = 4'd3,
		sensor_wall_e = 4'd4,
		sensor_wall_w = 4'd5
	} sensor_event_e;

	typedef enum logic [1:0] {
		move_stay = 2'd0,
		move_left = 2'd1,
		move_right = 2'd2
	} move_dir_e;

	typedef struct packed {
		logic [0:27][3:0] power; // A_B first, G_H last
		sensor_event_e sensor;
		word_t x_coord;
		word_t y_coord;
		word_t rx_checksum; // echoed by the ship in a later frame
	} game_state_t;

	typedef struct packed {
		logic [0:7][2:0] hookup; // crystal A first
		logic engines_on;
		move_dir_e engines_dir;
		move_dir_e sensor_move;
		logic [7:0] sensor_rate; // half degree steps per sample
		logic cannon_fire;
		logic [9:0] cannon_power;
		word_t tx_checksum;
	} ship_cmd_t;

	typedef struct packed {
		logic [BUF_ADDR_FIELD_W-1:0] addr;
		word_t data;
		logic we;
	} buf_wr_t;

	typedef enum logic [1:0] {rx_idle, rx_header, rx_payload} rx_state_e;
	typedef enum logic [1:0] {tx_wait_start, tx_header, tx_fetch, tx_payload} tx_state_e;
	typedef enum logic [2:0] {
		seq_idle, seq_read_addr, seq_read_data, seq_wait_tx, seq_write, seq_send
	} seq_state_e;

endpackage
